// ==== Bender.yml ====
package:
  name: lsu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lsu_pkg.sv
      - rtl/lsu_issue.sv
      - rtl/lsu_tag_queue.sv
      - rtl/lsu_load_format.sv
      - rtl/lsu_top.sv
  - target: test
    include_dirs:
      - rtl
      - verif
    files:
      - verif/lsu_tb.sv

// ==== rtl/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ------------------------------------------------------------
// Datapath
// ------------------------------------------------------------
`define LSU_XLEN            32
`define LSU_STRB_W          (`LSU_XLEN / 8)
`define LSU_TAGQ_DEPTH      2

// Major opcodes of loads and stores
`define LSU_OPC_LOAD        7'b0000011
`define LSU_OPC_STORE       7'b0100011

// funct3 encodings of the access size
`define LSU_F3_B            3'b000
`define LSU_F3_H            3'b001
`define LSU_F3_W            3'b010
`define LSU_F3_BU           3'b100
`define LSU_F3_HU           3'b101

// ------------------------------------------------------------
// Exception causes, bit 4 marks an exception
// ------------------------------------------------------------
`define LSU_EXC_W                   6
`define LSU_EXC_MISALIGNED_LOAD     6'h14
`define LSU_EXC_FAULT_LOAD          6'h15
`define LSU_EXC_MISALIGNED_STORE    6'h16
`define LSU_EXC_FAULT_STORE         6'h17

`endif

// ==== rtl/lsu_issue.sv ====
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_issue
    import lsu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  lsu_op_t   op_i,
    input  logic      mem_accept_i,
    input  mem_resp_t mem_resp_i,
    input  logic      fault_wb_i,
    output mem_req_t  mem_req_o,
    output logic      stall_o,
    output logic      tag_push_o,
    output lsu_tag_t  tag_o,
    output logic      misalign_done_o
);

    localparam int XLEN   = `LSU_XLEN;
    localparam int STRB_W = `LSU_STRB_W;

    logic [6:0]        opcode_w;
    logic [2:0]        funct3_w;
    logic              is_load_w;
    logic              is_store_w;
    logic              size_byte_w;
    logic              size_half_w;
    logic              size_word_w;
    logic [XLEN-1:0]   imm_w;
    logic [XLEN-1:0]   addr_w;
    logic              misalign_w;
    logic [XLEN-1:0]   lane_data_w;
    logic [STRB_W-1:0] lane_mask_w;

    lsu_tag_t          tag_q;
    logic [XLEN-1:0]   wdata_q;
    logic              rd_q;
    logic [STRB_W-1:0] wr_q;
    logic              misalign_e1_q;
    logic              misalign_e2_q;
    logic              pending_q;

    logic              delay_w;
    logic              req_valid_w;
    logic              issue_w;
    logic              misalign_push_w;
    logic              load_en_w;

    // ------------------------------------------------------------
    // Decode and address generation
    // ------------------------------------------------------------
    assign opcode_w = op_i.instr[6:0];
    assign funct3_w = op_i.instr[14:12];

    assign is_load_w = op_i.valid && (opcode_w == `LSU_OPC_LOAD) &&
                       ((funct3_w == `LSU_F3_B)  || (funct3_w == `LSU_F3_H) ||
                        (funct3_w == `LSU_F3_W)  || (funct3_w == `LSU_F3_BU) ||
                        (funct3_w == `LSU_F3_HU));

    assign is_store_w = op_i.valid && (opcode_w == `LSU_OPC_STORE) &&
                        ((funct3_w == `LSU_F3_B) || (funct3_w == `LSU_F3_H) ||
                         (funct3_w == `LSU_F3_W));

    // Low funct3 bits give the size for signed and unsigned forms alike
    assign size_byte_w = (funct3_w[1:0] == 2'b00);
    assign size_half_w = (funct3_w[1:0] == 2'b01);
    assign size_word_w = (funct3_w[1:0] == 2'b10);

    // I-type immediate for loads, S-type for stores
    always_comb
    begin
        if (is_store_w)
            imm_w = {{(XLEN-12){op_i.instr[31]}}, op_i.instr[31:25], op_i.instr[11:7]};
        else
            imm_w = {{(XLEN-12){op_i.instr[31]}}, op_i.instr[31:20]};
    end

    assign addr_w = op_i.base + imm_w;

    assign misalign_w = (is_load_w || is_store_w) &&
                        ((size_half_w && addr_w[0]) ||
                         (size_word_w && (addr_w[1:0] != 2'b00)));

    // Store data into byte lanes, unused lanes zero
    always_comb
    begin
        lane_data_w = op_i.store_data;
        lane_mask_w = {STRB_W{1'b1}};
        if (size_byte_w)
        begin
            lane_data_w = {{(XLEN-8){1'b0}}, op_i.store_data[7:0]};
            lane_mask_w = STRB_W'(1);
        end
        else if (size_half_w)
        begin
            lane_data_w = {{(XLEN-16){1'b0}}, op_i.store_data[15:0]};
            lane_mask_w = STRB_W'(3);
        end
        lane_data_w = lane_data_w << {addr_w[1:0], 3'b000};
        lane_mask_w = lane_mask_w << addr_w[1:0];
    end

    // ------------------------------------------------------------
    // Handshake and outstanding access
    // ------------------------------------------------------------
    // Response still owed by memory
    assign delay_w = pending_q && !mem_resp_i.ack;

    always_comb
    begin
        mem_req_o.addr  = {tag_q.addr[XLEN-1:2], 2'b00};
        mem_req_o.wdata = wdata_q;
        mem_req_o.rd    = rd_q && !delay_w;
        mem_req_o.wr    = wr_q & ~{STRB_W{delay_w}};
    end

    assign req_valid_w     = mem_req_o.rd || (|mem_req_o.wr);
    assign issue_w         = req_valid_w && mem_accept_i;
    assign misalign_push_w = misalign_e1_q && !delay_w;

    assign stall_o   = (req_valid_w && !mem_accept_i) || delay_w || misalign_e1_q;
    assign load_en_w = !stall_o;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            pending_q <= 1'b0;
        else if (issue_w)
            pending_q <= 1'b1;
        else if (mem_resp_i.ack)
            pending_q <= 1'b0;
    end

    // Misaligned op completes one cycle after it leaves E1
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            misalign_e2_q <= 1'b0;
        else
            misalign_e2_q <= misalign_push_w;
    end

    // ------------------------------------------------------------
    // Request register
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_q          <= 1'b0;
            wr_q          <= '0;
            misalign_e1_q <= 1'b0;
        end
        else if (load_en_w)
        begin
            // Op arriving with a fault writeback is squashed
            rd_q          <= is_load_w && !misalign_w && !fault_wb_i;
            wr_q          <= (is_store_w && !misalign_w && !fault_wb_i) ? lane_mask_w : '0;
            misalign_e1_q <= misalign_w && !fault_wb_i;
        end
        else if (misalign_push_w)
        begin
            misalign_e1_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (load_en_w)
        begin
            tag_q   <= '{addr:      addr_w,
                         is_load:   is_load_w,
                         is_byte:   size_byte_w,
                         is_half:   size_half_w,
                         is_signed: !funct3_w[2]};
            wdata_q <= lane_data_w;
        end
    end

    assign tag_push_o      = issue_w || misalign_push_w;
    assign tag_o           = tag_q;
    assign misalign_done_o = misalign_e2_q;

    // ------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------
    a_rd_wr_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(mem_req_o.rd && (|mem_req_o.wr)));

    // After a taken request the next one waits for its ack
    a_single_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
        issue_w |=> !issue_w until mem_resp_i.ack);

endmodule

// ==== rtl/lsu_load_format.sv ====
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_load_format
    import lsu_pkg::*;
(
    input  mem_resp_t mem_resp_i,
    input  lsu_tag_t  tag_i,
    input  logic      misalign_done_i,
    output lsu_wb_t   wb_o,
    output logic      fault_wb_o
);

    localparam int XLEN = `LSU_XLEN;

    logic            bus_err_w;
    logic [XLEN-1:0] lane_w;
    logic [XLEN-1:0] load_val_w;

    assign bus_err_w  = mem_resp_i.ack && mem_resp_i.error;
    assign fault_wb_o = bus_err_w || misalign_done_i;

    // ------------------------------------------------------------
    // Lane select and extension
    // ------------------------------------------------------------
    // Requested byte or halfword moved down to bit 0
    assign lane_w = mem_resp_i.rdata >> {tag_i.addr[1:0], 3'b000};

    always_comb
    begin
        if (tag_i.is_byte)
            load_val_w = {{(XLEN-8){tag_i.is_signed && lane_w[7]}}, lane_w[7:0]};
        else if (tag_i.is_half)
            load_val_w = {{(XLEN-16){tag_i.is_signed && lane_w[15]}}, lane_w[15:0]};
        else
            load_val_w = lane_w;
    end

    // ------------------------------------------------------------
    // Writeback
    // ------------------------------------------------------------
    always_comb
    begin
        wb_o.valid = mem_resp_i.ack || misalign_done_i;
        wb_o.value = '0;
        wb_o.exc   = '0;

        if (misalign_done_i)
        begin
            // Faulting address goes out as the value
            wb_o.value = tag_i.addr;
            if (tag_i.is_load)
                wb_o.exc = `LSU_EXC_MISALIGNED_LOAD;
            else
                wb_o.exc = `LSU_EXC_MISALIGNED_STORE;
        end
        else if (bus_err_w)
        begin
            wb_o.value = tag_i.addr;
            if (tag_i.is_load)
                wb_o.exc = `LSU_EXC_FAULT_LOAD;
            else
                wb_o.exc = `LSU_EXC_FAULT_STORE;
        end
        else if (mem_resp_i.ack && tag_i.is_load)
        begin
            wb_o.value = load_val_w;
        end
        // Store ack leaves value at zero
    end

endmodule

// ==== rtl/lsu_pkg.sv ====
`include "lsu_config.svh"

package lsu_pkg;

    // Operation handed over by the pipeline
    typedef struct packed {
        logic                 valid;
        logic [`LSU_XLEN-1:0] instr;
        logic [`LSU_XLEN-1:0] base;
        logic [`LSU_XLEN-1:0] store_data;
    } lsu_op_t;

    // Request towards data memory, address is word aligned
    typedef struct packed {
        logic [`LSU_XLEN-1:0]   addr;
        logic [`LSU_XLEN-1:0]   wdata;
        logic                   rd;
        logic [`LSU_STRB_W-1:0] wr;
    } mem_req_t;

    // Response from data memory
    typedef struct packed {
        logic                 ack;
        logic                 error;
        logic [`LSU_XLEN-1:0] rdata;
    } mem_resp_t;

    // Descriptor of an access in flight
    typedef struct packed {
        logic [`LSU_XLEN-1:0] addr;
        logic                 is_load;
        logic                 is_byte;
        logic                 is_half;
        logic                 is_signed;
    } lsu_tag_t;

    // Writeback towards the pipeline
    typedef struct packed {
        logic                  valid;
        logic [`LSU_XLEN-1:0]  value;
        logic [`LSU_EXC_W-1:0] exc;
    } lsu_wb_t;

endpackage

// ==== rtl/lsu_tag_queue.sv ====
`timescale 1ns/1ns
`include "lsu_config.svh"

module lsu_tag_queue
    import lsu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     push_i,
    input  lsu_tag_t tag_i,
    input  logic     pop_i,
    output lsu_tag_t tag_o
);

    localparam int DEPTH = `LSU_TAGQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    lsu_tag_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full_w;
    logic             empty_w;

    // Wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign full_w  = (count_q == CNT_W'(DEPTH));
    assign empty_w = (count_q == '0);

    // Entry storage
    always_ff @(posedge clk_i)
    begin
        if (push_i)
            mem_q[wr_ptr_q] <= tag_i;
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr_q <= ptr_next(wr_ptr_q);
            if (pop_i)
                rd_ptr_q <= ptr_next(rd_ptr_q);
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head is read combinationally by the formatter
    assign tag_o = mem_q[rd_ptr_q];

    a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
        !(push_i && full_w));

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        !(pop_i && empty_w));

endmodule

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top
    import lsu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  lsu_op_t   op_i,
    output logic      stall_o,
    output mem_req_t  mem_req_o,
    input  logic      mem_accept_i,
    input  mem_resp_t mem_resp_i,
    output lsu_wb_t   wb_o
);

    logic     tag_push_w;
    logic     tag_pop_w;
    lsu_tag_t tag_in_w;
    lsu_tag_t tag_head_w;
    logic     misalign_done_w;
    logic     fault_wb_w;

    // Entry retires on a memory ack or a misaligned completion
    assign tag_pop_w = mem_resp_i.ack || misalign_done_w;

    // ------------------------------------------------------------
    // Issue, in-flight tracking and response formatting
    // ------------------------------------------------------------
    lsu_issue lsu_issue_inst (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .op_i            (op_i),
        .mem_accept_i    (mem_accept_i),
        .mem_resp_i      (mem_resp_i),
        .fault_wb_i      (fault_wb_w),
        .mem_req_o       (mem_req_o),
        .stall_o         (stall_o),
        .tag_push_o      (tag_push_w),
        .tag_o           (tag_in_w),
        .misalign_done_o (misalign_done_w)
    );

    lsu_tag_queue lsu_tag_queue_inst (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .push_i (tag_push_w),
        .tag_i  (tag_in_w),
        .pop_i  (tag_pop_w),
        .tag_o  (tag_head_w)
    );

    lsu_load_format lsu_load_format_inst (
        .mem_resp_i      (mem_resp_i),
        .tag_i           (tag_head_w),
        .misalign_done_i (misalign_done_w),
        .wb_o            (wb_o),
        .fault_wb_o      (fault_wb_w)
    );

endmodule

// ==== tb.f ====
+incdir+rtl
+incdir+verif
rtl/lsu_pkg.sv
rtl/lsu_issue.sv
rtl/lsu_tag_queue.sv
rtl/lsu_load_format.sv
rtl/lsu_top.sv
verif/lsu_tb.sv

// ==== verif/lsu_model.svh ====
`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

`include "lsu_config.svh"

// Operation as issued, with its effective address
typedef struct packed {
    lsu_op_t     op;
    logic [31:0] addr;
    logic        is_load;
    logic [2:0]  f3;
} op_info_t;

// Reference copy of data memory, 64 words
logic [31:0] model_mem [64];

function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd2, `LSU_OPC_LOAD};
endfunction

function automatic logic [31:0] enc_store(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], `LSU_OPC_STORE};
endfunction

function automatic logic is_misaligned(input op_info_t o);
    return ((o.f3[1:0] == 2'b01) && o.addr[0]) ||
           ((o.f3[1:0] == 2'b10) && (o.addr[1:0] != 2'b00));
endfunction

// Byte-write mask for a store of this size and offset
function automatic logic [3:0] exp_mask(input op_info_t o);
    case (o.f3[1:0])
        2'b00:   return 4'b0001 << o.addr[1:0];
        2'b01:   return 4'b0011 << o.addr[1:0];
        default: return 4'b1111;
    endcase
endfunction

function automatic logic [31:0] exp_wdata(input op_info_t o);
    logic [31:0] d;
    d = o.op.store_data;
    if (o.f3[1:0] == 2'b00)
        d = {24'b0, d[7:0]};
    else if (o.f3[1:0] == 2'b01)
        d = {16'b0, d[15:0]};
    return d << (8 * o.addr[1:0]);
endfunction

// Writeback the pipeline should see for this op
function automatic lsu_wb_t expect_wb(input op_info_t o, input logic err);
    lsu_wb_t     e;
    logic [31:0] sh;
    e.valid = 1'b1;
    e.value = '0;
    e.exc   = '0;
    sh      = model_mem[o.addr[7:2]] >> (8 * o.addr[1:0]);
    if (is_misaligned(o))
    begin
        e.value = o.addr;
        e.exc   = o.is_load ? `LSU_EXC_MISALIGNED_LOAD : `LSU_EXC_MISALIGNED_STORE;
    end
    else if (err)
    begin
        e.value = o.addr;
        e.exc   = o.is_load ? `LSU_EXC_FAULT_LOAD : `LSU_EXC_FAULT_STORE;
    end
    else if (o.is_load)
    begin
        case (o.f3)
            `LSU_F3_B:  e.value = {{24{sh[7]}}, sh[7:0]};
            `LSU_F3_BU: e.value = {24'b0, sh[7:0]};
            `LSU_F3_H:  e.value = {{16{sh[15]}}, sh[15:0]};
            `LSU_F3_HU: e.value = {16'b0, sh[15:0]};
            default:    e.value = sh;
        endcase
    end
    return e;
endfunction

// Commit a successful store into the reference memory
task automatic model_store(input op_info_t o);
    logic [3:0]  m;
    logic [31:0] d;
    m = exp_mask(o);
    d = exp_wdata(o);
    for (int b = 0; b < 4; b++)
        if (m[b])
            model_mem[o.addr[7:2]][8*b +: 8] = d[8*b +: 8];
endtask

`endif

// ==== verif/lsu_tb.sv ====
`timescale 1ns/1ns

module lsu_tb
    import lsu_pkg::*;
;

`include "lsu_model.svh"

    localparam int OPS_PER_TEST = 40;
    localparam int CYCLE_LIMIT  = 40 * 5 * OPS_PER_TEST;

    logic      clk_i;
    logic      rst_i;
    lsu_op_t   op_i;
    logic      stall_o;
    mem_req_t  mem_req_o;
    logic      mem_accept_i;
    mem_resp_t mem_resp_i;
    lsu_wb_t   wb_o;

    logic [31:0] resp_mem [64];
    op_info_t    op_q [$];
    op_info_t    exp_q [$];
    op_info_t    cur;
    mem_req_t    prev_req;
    mem_req_t    acked_req;
    mem_req_t    busy_req;
    logic        prev_stall;
    logic        busy;
    logic        busy_err;
    logic        misalign_e1;
    logic [31:0] busy_rdata;
    int          busy_cnt;
    int          cycles;
    int          err_count;
    int          check_count;

    lsu_top lsu_top_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .op_i         (op_i),
        .stall_o      (stall_o),
        .mem_req_o    (mem_req_o),
        .mem_accept_i (mem_accept_i),
        .mem_resp_i   (mem_resp_i),
        .wb_o         (wb_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic check_eq(input string msg, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns %s: got %h expected %h", $time, msg, got, exp);
            err_count++;
        end
    endtask

    // ------------------------------------------------------------
    // One clock: sample, check, respond, drive
    // ------------------------------------------------------------
    task automatic step();
        lsu_wb_t   wb;
        mem_req_t  req;
        mem_resp_t resp;
        lsu_wb_t   e;
        op_info_t  o;
        logic      stall;
        logic      acc;
        logic      taken;
        logic      squash;
        @(posedge clk_i);
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Timeout: no progress after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
        else
        begin
            wb     = wb_o;
            req    = mem_req_o;
            resp   = mem_resp_i;
            stall  = stall_o;
            acc    = mem_accept_i;
            taken  = op_i.valid && !stall;
            squash = 1'b0;

            // Request must hold while stalled
            if (prev_stall)
            begin
                check_eq("held addr", req.addr, prev_req.addr);
                check_eq("held wdata", req.wdata, prev_req.wdata);
                if (prev_req.rd || (|prev_req.wr))
                begin
                    check_eq("held rd", req.rd, prev_req.rd);
                    check_eq("held mask", req.wr, prev_req.wr);
                end
            end
            prev_stall = stall;
            prev_req   = req;

            // Stall expected from the handshake state
            check_eq("stall", stall, ((req.rd || (|req.wr)) && !acc) || busy || misalign_e1);
            if (!busy)
                misalign_e1 = 1'b0;

            if (wb.valid)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("Error: writeback at %0t ns with no operation in flight", $time);
                    err_count++;
                end
                else
                begin
                    o = exp_q.pop_front();
                    e = expect_wb(o, resp.ack && resp.error);
                    check_eq("wb value", wb.value, e.value);
                    check_eq("wb exc", wb.exc, e.exc);
                    squash = (e.exc != '0);
                    if (!is_misaligned(o))
                    begin
                        check_eq("req addr", acked_req.addr, {o.addr[31:2], 2'b00});
                        check_eq("req rd", acked_req.rd, o.is_load);
                        check_eq("req mask", acked_req.wr, o.is_load ? 4'b0 : exp_mask(o));
                        if (!o.is_load)
                            check_eq("req wdata", acked_req.wdata, exp_wdata(o));
                    end
                    if (!o.is_load && (e.exc == '0))
                        model_store(o);
                end
            end

            if (taken && !squash)
            begin
                exp_q.push_back(cur);
                misalign_e1 = is_misaligned(cur);
            end

            // Memory responder
            if ((req.rd || (|req.wr)) && acc)
            begin
                busy_req   = req;
                busy_rdata = resp_mem[req.addr[7:2]];
                busy_err   = ($urandom % 10) == 0;
                if (!busy_err)
                    for (int b = 0; b < 4; b++)
                        if (req.wr[b])
                            resp_mem[req.addr[7:2]][8*b +: 8] = req.wdata[8*b +: 8];
                busy_cnt = 1 + ($urandom % 3);
                busy     = 1'b1;
            end

            #10;
            mem_resp_i = '0;
            if (busy)
            begin
                busy_cnt--;
                if (busy_cnt == 0)
                begin
                    mem_resp_i = '{ack: 1'b1, error: busy_err, rdata: busy_rdata};
                    acked_req  = busy_req;
                    busy       = 1'b0;
                end
            end
            mem_accept_i = ($urandom % 10) < 7;

            if (taken || !op_i.valid)
            begin
                if (op_q.size() != 0)
                begin
                    cur  = op_q.pop_front();
                    op_i = cur.op;
                end
                else
                begin
                    op_i = '0;
                end
            end
        end
    endtask

    function automatic op_info_t make_op(input logic ld, input logic [2:0] f3,
                                         input logic [31:0] addr, input logic [31:0] data);
        op_info_t    o;
        logic [11:0] imm;
        imm        = 12'($signed($urandom % 128) - 64);
        o.addr     = addr;
        o.is_load  = ld;
        o.f3       = f3;
        o.op.valid = 1'b1;
        o.op.instr = ld ? enc_load(f3, imm) : enc_store(f3, imm);
        o.op.base  = addr - {{20{imm[11]}}, imm};
        o.op.store_data = data;
        return o;
    endfunction

    // Kinds: 0 words, 1 sub-word, 2 misaligned, 3 legal mix, 4 full mix
    task automatic run_test(input string name, input int kind);
        logic [31:0] addrs [OPS_PER_TEST/2];
        logic [2:0]  f3;
        logic [31:0] a;
        logic        ld;
        int          errs_before;
        errs_before = err_count;
        for (int i = 0; i < OPS_PER_TEST; i++)
        begin
            ld = $urandom % 2;
            a  = $urandom % 256;
            if (kind == 0)
            begin
                if (i < OPS_PER_TEST/2)
                    addrs[i] = a & ~32'h3;
                op_q.push_back(make_op(i >= OPS_PER_TEST/2, `LSU_F3_W,
                                       addrs[i % (OPS_PER_TEST/2)], $urandom));
            end
            else
            begin
                case ($urandom % 5)
                    0:       f3 = `LSU_F3_B;
                    1:       f3 = `LSU_F3_H;
                    2:       f3 = `LSU_F3_W;
                    3:       f3 = `LSU_F3_BU;
                    default: f3 = `LSU_F3_HU;
                endcase
                if (kind == 1 && f3 == `LSU_F3_W)
                    f3 = `LSU_F3_B;
                if (!ld)
                    f3[2] = 1'b0;
                if (kind == 2)
                    a = (f3[1:0] == 2'b01) ? (a | 1) : ((f3[1:0] == 2'b10) ? (a | 2) : a);
                else if (kind != 4)
                    a = (f3[1:0] == 2'b01) ? (a & ~32'h1) :
                        ((f3[1:0] == 2'b10) ? (a & ~32'h3) : a);
                op_q.push_back(make_op(ld, f3, a, $urandom));
            end
        end
        while (op_q.size() != 0 || op_i.valid || exp_q.size() != 0)
            step();
        $display("Test %s finished with %0d mismatches", name, err_count - errs_before);
    endtask

    initial
    begin
        void'($urandom(18));
        rst_i        = 1'b1;
        op_i         = '0;
        mem_accept_i = 1'b0;
        mem_resp_i   = '0;
        prev_stall   = 1'b0;
        prev_req     = '0;
        acked_req    = '0;
        busy         = 1'b0;
        misalign_e1  = 1'b0;
        cycles       = 0;
        err_count    = 0;
        check_count  = 0;
        for (int i = 0; i < 64; i++)
        begin
            resp_mem[i]  = (i * 32'h9E3779B1) ^ i;
            model_mem[i] = (i * 32'h9E3779B1) ^ i;
        end
        repeat (5) @(posedge clk_i);
        #10;
        rst_i = 1'b0;

        run_test("aligned_words", 0);
        run_test("sub_word", 1);
        run_test("misaligned", 2);
        run_test("bus_errors", 3);
        run_test("backpressure_squash", 4);

        $display("Checks %0d, mismatches %0d, cycles %0d", check_count, err_count, cycles);
        if (err_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
